// File: hdl/phy_read_settings.svh
// read path settings for the latency counter width, tap count, data word width and FIFO depth
`ifndef PHY_READ_SETTINGS_SVH
`define PHY_READ_SETTINGS_SVH

// width of the calibrated read latency counter driven by the sequencer
// the counter selects one of the shifter taps, so it sets the tap count below
`define PHY_READ_LAT_W 4

// number of taps in the request shift register, one per possible latency value
`define PHY_READ_TAP_NUM (2**`PHY_READ_LAT_W)

// width of one word on the memory capture bus
// an AFI beat carries two of these words side by side
`define PHY_READ_DATA_W 16

// number of entries in the read data FIFO
// it must stay a power of two so the pointers wrap without extra logic
// the controller keeps its outstanding reads within this many words
`define PHY_READ_FIFO_DEPTH 16

`endif

// File: hdl/phy_read_pkg.sv
// shared types of the read path: captured word, AFI beat and packer state enum
`include "phy_read_settings.svh"

package phy_read_pkg;

	// one word as sampled from the capture bus
	// last_of_burst travels with the data so the burst boundary is never lost in the FIFO
	typedef struct packed {
		logic                        last_of_burst;
		logic [`PHY_READ_DATA_W-1:0] data;
	} rd_word_t;

	// one half-rate AFI beat built from two consecutive captured words
	// the earlier word sits in the low half and the later word in the high half
	typedef struct packed {
		logic [`PHY_READ_DATA_W-1:0] hi;
		logic [`PHY_READ_DATA_W-1:0] lo;
	} afi_beat_t;

	// states of the beat packer
	// PACK_EMPTY waits for the first word of a pair
	// PACK_HALF holds that first word and waits for the second one
	typedef enum logic {
		PACK_EMPTY = 1'b0,
		PACK_HALF  = 1'b1
	} pack_state_t;

endpackage

// File: hdl/read_latency_shifter.sv
// read_latency_shifter module, the tapped delay line for read request pulses
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module read_latency_shifter (
	input  logic                         pll_afi_clk,
	input  logic                         reset_n,
	// one-cycle pulse from the controller for every read burst it issues
	input  logic                         afi_rdata_en,
	// tap k holds the request that was sampled k+1 cycles ago
	output logic [`PHY_READ_TAP_NUM-1:0] latency_shifter
);

	// every flop in the chain adds one cycle of delay
	// a request sampled at clock t reaches tap 0 at t+1 and tap k at t+1+k
	// the chain is a plain bit vector, so any number of requests can be in flight
	// at once and back-to-back pulses stay separated by their original spacing
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// no request is pending after reset
			latency_shifter <= '0;
		end
		else
		begin
			// shift toward the high taps and insert the new request at tap 0
			latency_shifter <= {latency_shifter[`PHY_READ_TAP_NUM-2:0], afi_rdata_en};
		end
	end

	// the oldest request drops off the top tap
	// that is harmless because the largest latency value selects exactly that top tap

endmodule

// File: hdl/read_valid_selector.sv
// read_valid_selector module, latency decode and read valid strobe generation
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module read_valid_selector (
	input  logic                         pll_afi_clk,
	input  logic                         reset_n,
	input  logic [`PHY_READ_TAP_NUM-1:0] latency_shifter,
	// calibrated read latency, held static while reads are in flight
	input  logic [`PHY_READ_LAT_W-1:0]   latency_counter,
	// capture enable for the DQS logic, a copy of read_valid
	output logic                         read_enable,
	// high in the cycle when memory data is on the capture bus
	output logic                         read_valid
);

	// one-hot decode of the latency counter
	logic [`PHY_READ_TAP_NUM-1:0] selector;
	// registered mask, so a new latency value takes effect one cycle later
	logic [`PHY_READ_TAP_NUM-1:0] selector_reg;
	// the taps that are both selected and carrying a request
	logic [`PHY_READ_TAP_NUM-1:0] valid_select;

	// plain decoder in place of the vendor decode cell
	always_comb
	begin
		selector = '0;
		selector[latency_counter] = 1'b1;
	end

	// the mask register cuts the path from the sequencer into the tap compare
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			selector_reg <= '0;
		end
		else
		begin
			selector_reg <= selector;
		end
	end

	assign valid_select = selector_reg & latency_shifter;

	// a request from clock t is in tap L at t+1+L
	// so the output register raises the strobe at t+2+L
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_enable <= 1'b0;
			read_valid  <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select;
			read_valid  <= |valid_select;
		end
	end

	// from the second edge out of reset the mask must select exactly one tap
	a_mask_onehot: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		$past(reset_n) |-> $onehot(selector_reg));

endmodule

// File: hdl/read_data_fifo.sv
// read_data_fifo module, circular buffer of captured words with valid/ready output
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module read_data_fifo (
	input  logic                   pll_afi_clk,
	input  logic                   reset_n,
	// capture strobe from the selector
	input  logic                   wr_en,
	input  phy_read_pkg::rd_word_t wr_word,
	// output handshake toward the packer
	output logic                   word_valid,
	input  logic                   word_ready,
	output phy_read_pkg::rd_word_t word_data,
	// sticky, set by a write into a full buffer and cleared only by reset
	output logic                   fifo_overflow
);

	localparam int PTR_W = $clog2(`PHY_READ_FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`PHY_READ_FIFO_DEPTH);

	// storage for the captured words
	phy_read_pkg::rd_word_t mem [`PHY_READ_FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers so full and empty differ
	logic [CNT_W-1:0] count;
	logic             full;
	logic             wr_accept;
	logic             rd_fire;

	assign full       = (count == FULL_COUNT);
	assign word_valid = (count != '0);
	// a word that arrives while the buffer is full is dropped
	assign wr_accept  = wr_en && !full;
	assign rd_fire    = word_valid && word_ready;

	// the head entry is read straight from the array
	// a word written at clock c is therefore visible from c+1
	assign word_data = mem[rd_ptr];

	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_accept)
		begin
			mem[wr_ptr] <= wr_word;
		end
	end

	// pointers wrap by themselves because the depth is a power of two
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			if (wr_accept)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// a write and a read in the same cycle leave the count unchanged
			case ({wr_accept, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_en && full)
			begin
				fifo_overflow <= 1'b1;
			end
		end
	end

	// a stalled head word must neither vanish nor change
	a_head_stable: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		word_valid && !word_ready |=> word_valid && $stable(word_data));

	a_count_bound: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		count <= FULL_COUNT);

endmodule

// File: hdl/read_beat_packer.sv
// read_beat_packer module, pairs consecutive words into AFI beats under valid/ready
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module read_beat_packer (
	input  logic                    pll_afi_clk,
	input  logic                    reset_n,
	// word stream from the FIFO
	input  logic                    word_valid,
	output logic                    word_ready,
	input  phy_read_pkg::rd_word_t  word_data,
	// beat stream toward the AFI side
	output logic                    afi_rdata_valid,
	input  logic                    afi_rdata_ready,
	output phy_read_pkg::afi_beat_t afi_rdata
);

	phy_read_pkg::pack_state_t state;
	// first word of the current pair, only its data goes into the beat
	logic [`PHY_READ_DATA_W-1:0] low_word;
	logic                        word_fire;
	logic                        beat_fire;

	// the first word of a pair can always be taken since it does not touch the beat
	// the second word needs the output register free, or emptying in this very cycle
	assign word_ready = !((state == phy_read_pkg::PACK_HALF) && afi_rdata_valid &&
		!afi_rdata_ready);
	assign word_fire  = word_valid && word_ready;
	assign beat_fire  = afi_rdata_valid && afi_rdata_ready;

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state           <= phy_read_pkg::PACK_EMPTY;
			afi_rdata_valid <= 1'b0;
		end
		else
		begin
			case (state)
				phy_read_pkg::PACK_EMPTY:
				begin
					if (word_fire)
					begin
						state <= phy_read_pkg::PACK_HALF;
					end
				end
				phy_read_pkg::PACK_HALF:
				begin
					if (word_fire)
					begin
						state <= phy_read_pkg::PACK_EMPTY;
					end
				end
				default:
				begin
					state <= phy_read_pkg::PACK_EMPTY;
				end
			endcase
			// a completed pair loads the beat, which wins over a beat leaving
			if (word_fire && (state == phy_read_pkg::PACK_HALF))
			begin
				afi_rdata_valid <= 1'b1;
			end
			else if (beat_fire)
			begin
				afi_rdata_valid <= 1'b0;
			end
		end
	end

	// payload registers load only on an accepted word
	always_ff @(posedge pll_afi_clk)
	begin
		if (word_fire && (state == phy_read_pkg::PACK_EMPTY))
		begin
			low_word <= word_data.data;
		end
		if (word_fire && (state == phy_read_pkg::PACK_HALF))
		begin
			afi_rdata.lo <= low_word;
			afi_rdata.hi <= word_data.data;
		end
	end

	a_beat_stable: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		afi_rdata_valid && !afi_rdata_ready |=> afi_rdata_valid && $stable(afi_rdata));

endmodule

// File: hdl/phy_read_path.sv
// phy_read_path module, top level of the read-return path from request to AFI beat
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module phy_read_path (
	input  logic                    pll_afi_clk,
	input  logic                    reset_n,
	// read request pulse, one per issued burst
	input  logic                    afi_rdata_en,
	// calibrated latency from the sequencer
	input  logic [`PHY_READ_LAT_W-1:0] latency_counter,
	// capture bus from the memory
	input  phy_read_pkg::rd_word_t  mem_rdata,
	input  logic                    afi_rdata_ready,
	output phy_read_pkg::afi_beat_t afi_rdata,
	output logic                    afi_rdata_valid,
	// capture strobe, brought out so the sequencer can observe it
	output logic                    read_valid,
	output logic                    fifo_overflow
);

	// delayed request taps from shifter to selector
	logic [`PHY_READ_TAP_NUM-1:0] latency_shifter;
	// word handshake between FIFO and packer
	logic                         word_valid;
	logic                         word_ready;
	phy_read_pkg::rd_word_t       word_data;

	read_latency_shifter read_latency_shifter_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_rdata_en    (afi_rdata_en),
		.latency_shifter (latency_shifter)
	);

	// read_enable only feeds DQS capture logic, which is not part of this path
	read_valid_selector read_valid_selector_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_counter),
		.read_enable     (),
		.read_valid      (read_valid)
	);

	// the strobe writes whatever is on the capture bus in that same cycle
	read_data_fifo read_data_fifo_inst (
		.pll_afi_clk   (pll_afi_clk),
		.reset_n       (reset_n),
		.wr_en         (read_valid),
		.wr_word       (mem_rdata),
		.word_valid    (word_valid),
		.word_ready    (word_ready),
		.word_data     (word_data),
		.fifo_overflow (fifo_overflow)
	);

	read_beat_packer read_beat_packer_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.word_valid      (word_valid),
		.word_ready      (word_ready),
		.word_data       (word_data),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rdata_ready (afi_rdata_ready),
		.afi_rdata       (afi_rdata)
	);

endmodule

// File: verif/tb_clock_gen.sv
// tb_clock_gen module, the AFI clock source and the power-on reset of the testbench
`timescale 1ns/1ps

module tb_clock_gen (
	output logic pll_afi_clk,
	output logic reset_n
);

	// half of the 20 ns AFI clock period
	localparam int HALF_PERIOD = 10;
	// number of rising edges that see reset held low
	localparam int RESET_CYCLES = 4;

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #HALF_PERIOD pll_afi_clk = ~pll_afi_clk;
	end

	// release lands 2 ns after an edge, in step with the rest of the stimulus
	initial
	begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		#2;
		reset_n = 1'b1;
	end

endmodule

// File: verif/phy_read_path_checker.sv
// phy_read_path_checker module, compares DUT strobes and beats with the expected stream
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module phy_read_path_checker (
	input  logic                       pll_afi_clk,
	input  logic                       reset_n,
	input  logic [`PHY_READ_LAT_W-1:0] latency_counter,
	input  logic                       read_valid,
	input  logic                       exp_read_valid,
	input  phy_read_pkg::afi_beat_t    afi_rdata,
	input  logic                       afi_rdata_valid,
	input  logic                       afi_rdata_ready,
	input  logic                       fifo_overflow,
	input  logic                       ovf_expect,
	// one pulse per expected beat, in the order the words were captured
	input  logic                       exp_push,
	input  phy_read_pkg::afi_beat_t    exp_beat,
	input  logic                       test_end,
	input  int                         test_num,
	input  logic                       run_end,
	output int                         pending,
	output int                         error_count
);

	phy_read_pkg::afi_beat_t exp_q[$];
	// beat seen on the last sample while the AFI side stalled
	phy_read_pkg::afi_beat_t held_beat;
	phy_read_pkg::afi_beat_t want;
	logic held = 1'b0;
	int test_errors = 0;
	int test_beats = 0;
	int total_beats = 0;
	int tests_done = 0;

	initial
	begin
		pending = 0;
		error_count = 0;
	end

	task automatic value_error(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		error_count++;
		test_errors++;
	endtask

	// sampling on the falling edge sees inputs settled and outputs between updates
	always @(negedge pll_afi_clk)
	begin
		if (exp_push)
			exp_q.push_back(exp_beat);
		// the strobe must match the memory model's schedule cycle for cycle
		if (read_valid !== exp_read_valid)
			value_error("read_valid", exp_read_valid, read_valid);
		if (!ovf_expect && fifo_overflow !== 1'b0)
			value_error("fifo_overflow", 0, fifo_overflow);
		if (!reset_n && afi_rdata_valid !== 1'b0)
			value_error("afi_rdata_valid", 0, afi_rdata_valid);
		// a stalled beat has to stay up and unchanged
		if (held && afi_rdata_valid !== 1'b1)
			value_error("afi_rdata_valid", 1, afi_rdata_valid);
		else if (held && afi_rdata !== held_beat)
			value_error("afi_rdata", held_beat, afi_rdata);
		if (reset_n && afi_rdata_valid && afi_rdata_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected beat at %0d ns with no word pair outstanding", $time);
				error_count++;
				test_errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				if (afi_rdata !== want)
					value_error("afi_rdata", want, afi_rdata);
				test_beats++;
			end
		end
		held = reset_n && afi_rdata_valid && !afi_rdata_ready;
		held_beat = afi_rdata;
		if (test_end)
		begin
			if (ovf_expect && fifo_overflow !== 1'b1)
				value_error("fifo_overflow", 1, fifo_overflow);
			$display("test %0d at latency %0d: %0d beats, %0d errors", test_num,
				latency_counter, test_beats, test_errors);
			tests_done++;
			total_beats += test_beats;
			test_beats = 0;
			test_errors = 0;
		end
		if (run_end)
			$display("%0d tests, %0d beats, %0d errors", tests_done, total_beats, error_count);
		pending = exp_q.size();
	end

endmodule

// File: verif/phy_read_path_tb.sv
// phy_read_path_tb module, stimulus, memory model, reference pairing and run limit
`timescale 1ns/1ps
`include "phy_read_settings.svh"

module phy_read_path_tb;

	localparam int NUM_TESTS = 7;
	// the random test sends the most bursts and latency 15 is the slowest
	localparam int MAX_BURSTS = 32;
	localparam int MAX_LAT = `PHY_READ_TAP_NUM - 1;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_BURSTS * (16 + MAX_LAT) + 200);

	logic                       pll_afi_clk;
	logic                       reset_n;
	logic                       afi_rdata_en;
	logic [`PHY_READ_LAT_W-1:0] latency_counter;
	phy_read_pkg::rd_word_t     mem_rdata;
	logic                       afi_rdata_ready;
	phy_read_pkg::afi_beat_t    afi_rdata;
	logic                       afi_rdata_valid;
	logic                       read_valid;
	logic                       fifo_overflow;
	// expectations handed to the checker
	logic                       exp_read_valid;
	logic                       exp_push;
	phy_read_pkg::afi_beat_t    exp_beat;
	logic                       ovf_expect;
	logic                       test_end;
	logic                       run_end;
	int                         test_num;
	int                         pending;
	int                         error_count;
	int                         cycle = 0;
	int                         seed;
	// 0 holds ready high, 1 randomizes it, 2 holds it low
	int                         ready_mode;
	logic                       beat_check;
	logic [`PHY_READ_DATA_W-1:0] word_cnt;
	logic [`PHY_READ_DATA_W-1:0] prev_word;
	// capture cycle of every request still in flight, oldest first
	int                         due_q[$];

	tb_clock_gen clock_gen_inst (
		.pll_afi_clk (pll_afi_clk),
		.reset_n     (reset_n)
	);

	phy_read_path phy_read_path_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_rdata_en    (afi_rdata_en),
		.latency_counter (latency_counter),
		.mem_rdata       (mem_rdata),
		.afi_rdata_ready (afi_rdata_ready),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid),
		.read_valid      (read_valid),
		.fifo_overflow   (fifo_overflow)
	);

	phy_read_path_checker checker_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_counter (latency_counter),
		.read_valid      (read_valid),
		.exp_read_valid  (exp_read_valid),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rdata_ready (afi_rdata_ready),
		.fifo_overflow   (fifo_overflow),
		.ovf_expect      (ovf_expect),
		.exp_push        (exp_push),
		.exp_beat        (exp_beat),
		.test_end        (test_end),
		.test_num        (test_num),
		.run_end         (run_end),
		.pending         (pending),
		.error_count     (error_count)
	);

	// word 2n fills the low half of a beat and word 2n+1 the high half
	function automatic phy_read_pkg::afi_beat_t pair_words(
		input logic [`PHY_READ_DATA_W-1:0] first, input logic [`PHY_READ_DATA_W-1:0] second);
		pair_words.lo = first;
		pair_words.hi = second;
	endfunction

	// memory model and ready driver, both 2 ns after the edge
	always @(posedge pll_afi_clk)
	begin
		cycle = cycle + 1;
		#2;
		exp_push = 1'b0;
		if (due_q.size() != 0 && due_q[0] == cycle)
		begin
			due_q.delete(0);
			mem_rdata.data = word_cnt;
			mem_rdata.last_of_burst = word_cnt[0];
			exp_read_valid = 1'b1;
			if (beat_check && word_cnt[0])
			begin
				exp_beat = pair_words(prev_word, word_cnt);
				exp_push = 1'b1;
			end
			prev_word = word_cnt;
			word_cnt = word_cnt + 1'b1;
		end
		else
		begin
			mem_rdata = '0;
			exp_read_valid = 1'b0;
		end
		case (ready_mode)
			0:       afi_rdata_ready = 1'b1;
			1:       afi_rdata_ready = (($random(seed) & 3) != 0);
			default: afi_rdata_ready = 1'b0;
		endcase
	end

	always @(posedge pll_afi_clk)
	begin
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("run stopped after %0d cycles before all beats came out", cycle);
			$display("Test failed");
			$finish;
		end
	end

	// a request driven in cycle n puts its word on the capture bus in cycle n+2+latency
	task automatic drive_cycle(input logic req);
		@(posedge pll_afi_clk);
		#2;
		afi_rdata_en = req;
		if (req)
			due_q.push_back(cycle + 2 + latency_counter);
	endtask

	// old requests must leave the top tap before the mask moves
	task automatic set_latency(input int lat);
		repeat (`PHY_READ_TAP_NUM + 2) drive_cycle(1'b0);
		latency_counter = lat;
		repeat (3) drive_cycle(1'b0);
	endtask

	task automatic finish_test();
		do
			@(negedge pll_afi_clk);
		while (due_q.size() != 0 || exp_push || pending != 0);
		repeat (4) drive_cycle(1'b0);
		test_end = 1'b1;
		drive_cycle(1'b0);
		test_end = 1'b0;
		test_num++;
	endtask

	// two lone requests, so only one read is ever in flight
	task automatic single_requests(input int lat);
		set_latency(lat);
		repeat (2)
		begin
			drive_cycle(1'b1);
			repeat (lat + 4) drive_cycle(1'b0);
		end
		finish_test();
	endtask

	initial
	begin
		int sent;
		logic req;
		seed = 32'h0f2960c5;
		afi_rdata_en = 1'b0;
		latency_counter = '0;
		mem_rdata = '0;
		afi_rdata_ready = 1'b1;
		exp_read_valid = 1'b0;
		exp_push = 1'b0;
		exp_beat = '0;
		ovf_expect = 1'b0;
		test_end = 1'b0;
		run_end = 1'b0;
		test_num = 1;
		ready_mode = 0;
		beat_check = 1'b1;
		word_cnt = '0;
		prev_word = '0;
		@(posedge reset_n);
		// quiet outputs straight after reset
		repeat (6) drive_cycle(1'b0);
		finish_test();
		single_requests(0);
		single_requests(5);
		single_requests(15);
		// eight reads overlap in the shifter at latency 7
		set_latency(7);
		repeat (16) drive_cycle(1'b1);
		drive_cycle(1'b0);
		finish_test();
		// random request gaps against random back-pressure
		set_latency(3);
		ready_mode = 1;
		sent = 0;
		while (sent < MAX_BURSTS)
		begin
			req = $random(seed) & 1;
			drive_cycle(req);
			sent += req;
		end
		drive_cycle(1'b0);
		finish_test();
		ready_mode = 0;
		// the packer soaks up three words ahead of the FIFO, so four extra overflow it
		set_latency(2);
		ready_mode = 2;
		beat_check = 1'b0;
		ovf_expect = 1'b1;
		repeat (`PHY_READ_FIFO_DEPTH + 4) drive_cycle(1'b1);
		drive_cycle(1'b0);
		finish_test();
		run_end = 1'b1;
		drive_cycle(1'b0);
		run_end = 1'b0;
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/phy_read_pkg.sv
hdl/read_latency_shifter.sv
hdl/read_valid_selector.sv
hdl/read_data_fifo.sv
hdl/read_beat_packer.sv
hdl/phy_read_path.sv
verif/tb_clock_gen.sv
verif/phy_read_path_checker.sv
verif/phy_read_path_tb.sv

// File: Bender.yml
package:
  name: phy_read_path

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/phy_read_pkg.sv
      - hdl/read_latency_shifter.sv
      - hdl/read_valid_selector.sv
      - hdl/read_data_fifo.sv
      - hdl/read_beat_packer.sv
      - hdl/phy_read_path.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/tb_clock_gen.sv
      - verif/phy_read_path_checker.sv
      - verif/phy_read_path_tb.sv
